// ==== sram_ctrl_macros.svh ====
// Scrambled SRAM controller sizes and constants
// Default key material and LFSR feedback for the init fill

`ifndef SRAM_CTRL_MACROS_SVH
`define SRAM_CTRL_MACROS_SVH

// Memory geometry
`define SRAM_DATA_W 32
`define SRAM_DEPTH 256
`define SRAM_ADDR_W 8

// Key and nonce share one width
`define SRAM_KEY_W 32

// Key material used after reset and after escalation
`define SRAM_DEFAULT_KEY 32'h3C5A_96E1
`define SRAM_DEFAULT_NONCE 32'h0F1E_2D3B

// Odd multiplier that spreads the word address over the keystream
`define SRAM_ADDR_MIX 32'h9E37_79B9

// Galois feedback mask, applied when the shifted-out bit is set
`define SRAM_LFSR_TAPS 32'h8020_0003

`endif

// ==== sram_ctrl_pkg.sv ====
// Scrambled SRAM controller package
// Vector types for data, addresses and key material, plus the FSM encodings

`default_nettype none

`include "sram_ctrl_macros.svh"

package sram_ctrl_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // One stored word
  typedef logic [`SRAM_DATA_W-1:0] data_t;

  // Word address into the array
  typedef logic [`SRAM_ADDR_W-1:0] addr_t;

  // Key or nonce
  typedef logic [`SRAM_KEY_W-1:0] key_t;

  //////////////////////////////
  // FSM encodings
  //////////////////////////////

  // Four-phase key exchange toward the key source
  typedef enum logic [1:0] {
    KeyIdle,
    KeyReq,
    KeyRelease
  } key_state_e;

  // Hardware init fill
  typedef enum logic [1:0] {
    InitIdle,
    InitWait,
    InitFill
  } init_state_e;

endpackage

`default_nettype wire

// ==== sram_key_req.sv ====
// Key requester for the scrambled SRAM
// Runs the four-phase exchange, holds key and nonce, scraps them on escalation

`timescale 1ns/1ns
`default_nettype none

`include "sram_ctrl_macros.svh"

module sram_key_req (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                renew_key_i,
  input  wire logic                escalate_i,
  input  wire logic                init_busy_i,
  input  wire logic                key_ack_i,
  input  wire sram_ctrl_pkg::key_t key_i,
  input  wire sram_ctrl_pkg::key_t nonce_i,
  output logic                     key_req_o,
  output logic                     key_pending_o,
  output logic                     escalated_o,
  output sram_ctrl_pkg::key_t      key_o,
  output sram_ctrl_pkg::key_t      nonce_o
);

  sram_ctrl_pkg::key_state_e state_q, state_d;
  sram_ctrl_pkg::key_t       key_q, nonce_q;
  logic                      escalated_q;
  logic                      capture;

  //////////////////////////////
  // Exchange FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    unique case (state_q)
      sram_ctrl_pkg::KeyIdle: begin
        // New requests only from a quiet, unescalated controller
        if (renew_key_i && !init_busy_i && !escalated_q) begin
          state_d = sram_ctrl_pkg::KeyReq;
        end
      end
      sram_ctrl_pkg::KeyReq: begin
        // Key and nonce are valid alongside the ack
        if (key_ack_i) begin
          capture = 1'b1;
          state_d = sram_ctrl_pkg::KeyRelease;
        end
      end
      sram_ctrl_pkg::KeyRelease: begin
        // Wait for the source to drop its ack
        if (!key_ack_i) begin
          state_d = sram_ctrl_pkg::KeyIdle;
        end
      end
      default: state_d = sram_ctrl_pkg::KeyIdle;
    endcase
  end

  //////////////////////////////
  // State and key registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= sram_ctrl_pkg::KeyIdle;
      escalated_q <= 1'b0;
      key_q       <= `SRAM_DEFAULT_KEY;
      nonce_q     <= `SRAM_DEFAULT_NONCE;
    end else begin
      state_q <= state_d;
      // Sticky until reset
      if (escalate_i) begin
        escalated_q <= 1'b1;
      end
      // Escalation wins over a capture in the same cycle
      if (escalate_i || escalated_q) begin
        key_q   <= `SRAM_DEFAULT_KEY;
        nonce_q <= `SRAM_DEFAULT_NONCE;
      end else if (capture) begin
        key_q   <= key_i;
        nonce_q <= nonce_i;
      end
    end
  end

  assign key_req_o     = (state_q == sram_ctrl_pkg::KeyReq);
  assign key_pending_o = (state_q != sram_ctrl_pkg::KeyIdle);
  assign escalated_o   = escalated_q;
  assign key_o         = key_q;
  assign nonce_o       = nonce_q;

  // Request is only withdrawn once the source has answered
  a_req_held_until_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(key_req_o) |-> $past(key_ack_i)
  );

endmodule

`default_nettype wire

// ==== sram_init_arb.sv ====
// Init fill engine and memory port arbiter
// Fills the array from a nonce-seeded LFSR and merges host accesses onto one port

`timescale 1ns/1ns
`default_nettype none

`include "sram_ctrl_macros.svh"

module sram_init_arb (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 init_i,
  input  wire logic                 key_pending_i,
  input  wire logic                 escalated_i,
  input  wire sram_ctrl_pkg::key_t  seed_i,
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire sram_ctrl_pkg::addr_t addr_i,
  input  wire sram_ctrl_pkg::data_t wdata_i,
  output logic                      gnt_o,
  output logic                      init_busy_o,
  output logic                      init_done_o,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output sram_ctrl_pkg::addr_t      mem_addr_o,
  output sram_ctrl_pkg::data_t      mem_wdata_o
);

  // One spare bit so the counter range is checkable
  localparam int unsigned CntW = `SRAM_ADDR_W + 1;
  typedef logic [CntW-1:0] cnt_t;

  sram_ctrl_pkg::init_state_e state_q, state_d;
  cnt_t                       fill_cnt_q;
  sram_ctrl_pkg::key_t        lfsr_q;
  logic                       init_done_q, ready_q;
  logic                       init_start, seed_load, fill_act, fill_last, host_acc;

  // One Galois step, shift right and fold in the taps
  function automatic sram_ctrl_pkg::key_t lfsr_step(input sram_ctrl_pkg::key_t s);
    sram_ctrl_pkg::key_t nxt;
    nxt = s >> 1;
    if (s[0]) begin
      nxt = nxt ^ `SRAM_LFSR_TAPS;
    end
    return nxt;
  endfunction

  //////////////////////////////
  // Init FSM
  //////////////////////////////

  assign init_start = (state_q == sram_ctrl_pkg::InitIdle) && init_i && !escalated_i;
  // Fill starts once no key exchange is in flight
  assign seed_load  = (state_q == sram_ctrl_pkg::InitWait) && !key_pending_i;
  assign fill_act   = (state_q == sram_ctrl_pkg::InitFill);
  assign fill_last  = fill_act && (fill_cnt_q == cnt_t'(`SRAM_DEPTH - 1));

  always_comb begin
    state_d = state_q;
    if (init_start) begin
      state_d = sram_ctrl_pkg::InitWait;
    end else if (seed_load) begin
      state_d = sram_ctrl_pkg::InitFill;
    end else if (fill_last) begin
      state_d = sram_ctrl_pkg::InitIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= sram_ctrl_pkg::InitIdle;
      fill_cnt_q  <= '0;
      init_done_q <= 1'b0;
      ready_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= 1'b1;
      // Counter parks on the last address once the fill ends
      if (seed_load) begin
        fill_cnt_q <= '0;
      end else if (fill_act && !fill_last) begin
        fill_cnt_q <= fill_cnt_q + cnt_t'(1);
      end
      // Done flag drops on a new init or on escalation
      if (init_start || escalated_i) begin
        init_done_q <= 1'b0;
      end else if (fill_last) begin
        init_done_q <= 1'b1;
      end
    end
  end

  // Seed has bit 0 forced so the LFSR never locks up at zero
  always_ff @(posedge clk_i) begin
    if (seed_load) begin
      lfsr_q <= seed_i | sram_ctrl_pkg::key_t'(1);
    end else if (fill_act) begin
      lfsr_q <= lfsr_step(lfsr_q);
    end
  end

  //////////////////////////////
  // Grant and port merge
  //////////////////////////////

  // Grant comes from state only, never from req_i
  assign init_busy_o = (state_q != sram_ctrl_pkg::InitIdle);
  assign gnt_o       = ready_q & ~key_pending_i & ~init_busy_o & ~escalated_i;
  assign init_done_o = init_done_q;
  assign host_acc    = req_i & gnt_o;

  assign mem_req_o   = fill_act | host_acc;
  assign mem_we_o    = fill_act | we_i;
  assign mem_addr_o  = fill_act ? sram_ctrl_pkg::addr_t'(fill_cnt_q[`SRAM_ADDR_W-1:0]) : addr_i;
  assign mem_wdata_o = fill_act ? sram_ctrl_pkg::data_t'(lfsr_q) : wdata_i;

  a_port_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(host_acc && fill_act)
  );

  a_fill_cnt_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_cnt_q < cnt_t'(`SRAM_DEPTH)
  );

endmodule

`default_nettype wire

// ==== sram_scr_mem.sv ====
// Scrambled memory array
// Words are stored XORed with an address keystream and descrambled on read

`timescale 1ns/1ns
`default_nettype none

`include "sram_ctrl_macros.svh"

module sram_scr_mem (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 mem_req_i,
  input  wire logic                 mem_we_i,
  input  wire sram_ctrl_pkg::addr_t mem_addr_i,
  input  wire sram_ctrl_pkg::data_t mem_wdata_i,
  input  wire sram_ctrl_pkg::key_t  key_i,
  input  wire sram_ctrl_pkg::key_t  nonce_i,
  output logic                      rvalid_o,
  output sram_ctrl_pkg::data_t      rdata_o
);

  sram_ctrl_pkg::data_t mem_q [`SRAM_DEPTH];
  sram_ctrl_pkg::data_t rdata_q;
  sram_ctrl_pkg::data_t ks;
  logic                 rvalid_q;
  logic                 rd_req, wr_req;

  //////////////////////////////
  // Keystream
  //////////////////////////////

  // Key and nonce folded with the address times an odd constant
  function automatic sram_ctrl_pkg::data_t keystream(
    input sram_ctrl_pkg::addr_t addr,
    input sram_ctrl_pkg::key_t  key,
    input sram_ctrl_pkg::key_t  nonce
  );
    sram_ctrl_pkg::key_t mix;
    mix = sram_ctrl_pkg::key_t'(addr) * `SRAM_ADDR_MIX;
    return sram_ctrl_pkg::data_t'(key ^ nonce ^ mix);
  endfunction

  // Same keystream serves both directions of the port
  assign ks     = keystream(mem_addr_i, key_i, nonce_i);
  assign rd_req = mem_req_i & ~mem_we_i;
  assign wr_req = mem_req_i & mem_we_i;

  //////////////////////////////
  // Array
  //////////////////////////////

  // Write lands at the end of the grant cycle
  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      mem_q[mem_addr_i] <= mem_wdata_i ^ ks;
    end
  end

  // Descramble with the key of the grant cycle, so a key
  // change on the next edge cannot garble this read
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rdata_q <= mem_q[mem_addr_i] ^ ks;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Response strictly one cycle after a read
  a_rvalid_follows_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(mem_req_i && !mem_we_i)
  );

endmodule

`default_nettype wire

// ==== sram_ctrl.sv ====
// Scrambled SRAM controller top level
// Key requester, init/arbitration block and scrambled memory

`timescale 1ns/1ns
`default_nettype none

module sram_ctrl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Host port
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire sram_ctrl_pkg::addr_t addr_i,
  input  wire sram_ctrl_pkg::data_t wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output sram_ctrl_pkg::data_t      rdata_o,
  // Commands
  input  wire logic                 renew_key_i,
  input  wire logic                 init_i,
  input  wire logic                 escalate_i,
  // Key source
  output logic                      key_req_o,
  input  wire logic                 key_ack_i,
  input  wire sram_ctrl_pkg::key_t  key_i,
  input  wire sram_ctrl_pkg::key_t  nonce_i,
  // Status
  output logic                      key_valid_o,
  output logic                      init_done_o,
  output logic                      escalated_o
);

  logic                 key_pending, init_busy;
  sram_ctrl_pkg::key_t  key, nonce;
  logic                 mem_req, mem_we;
  sram_ctrl_pkg::addr_t mem_addr;
  sram_ctrl_pkg::data_t mem_wdata;

  //////////////////////////////
  // Key requester
  //////////////////////////////

  sram_key_req u_key_req (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .renew_key_i   (renew_key_i),
    .escalate_i    (escalate_i),
    .init_busy_i   (init_busy),
    .key_ack_i     (key_ack_i),
    .key_i         (key_i),
    .nonce_i       (nonce_i),
    .key_req_o     (key_req_o),
    .key_pending_o (key_pending),
    .escalated_o   (escalated_o),
    .key_o         (key),
    .nonce_o       (nonce)
  );

  // Key usable only when idle and not scrapped
  assign key_valid_o = ~(key_pending | escalated_o);

  //////////////////////////////
  // Init and arbitration
  //////////////////////////////

  // Fill seed is the current nonce
  sram_init_arb u_init_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_i        (init_i),
    .key_pending_i (key_pending),
    .escalated_i   (escalated_o),
    .seed_i        (nonce),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .gnt_o         (gnt_o),
    .init_busy_o   (init_busy),
    .init_done_o   (init_done_o),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata)
  );

  //////////////////////////////
  // Scrambled memory
  //////////////////////////////

  sram_scr_mem u_scr_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .key_i       (key),
    .nonce_i     (nonce),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

// ==== sram_ctrl_checker.sv ====
// Checker for the scrambled SRAM controller
// Models stored words, key state and status flags, and compares them every cycle

`timescale 1ns/1ns
`default_nettype none

`include "sram_ctrl_macros.svh"

module sram_ctrl_checker (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Host port as seen at the DUT
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire sram_ctrl_pkg::addr_t addr_i,
  input  wire sram_ctrl_pkg::data_t wdata_i,
  input  wire logic                 gnt_i,
  input  wire logic                 rvalid_i,
  input  wire sram_ctrl_pkg::data_t rdata_i,
  // Commands, key source and status
  input  wire logic                 renew_key_i,
  input  wire logic                 init_i,
  input  wire logic                 escalate_i,
  input  wire logic                 key_req_i,
  input  wire logic                 key_ack_i,
  input  wire sram_ctrl_pkg::key_t  key_i,
  input  wire sram_ctrl_pkg::key_t  nonce_i,
  input  wire logic                 key_valid_i,
  input  wire logic                 init_done_i,
  input  wire logic                 escalated_i,
  output int unsigned               check_cnt_o,
  output int unsigned               error_cnt_o
);

  sram_ctrl_pkg::data_t      scr_mem [`SRAM_DEPTH];
  logic                      written [`SRAM_DEPTH];
  sram_ctrl_pkg::key_t       key_m, nonce_m;
  sram_ctrl_pkg::key_state_e phase;
  sram_ctrl_pkg::data_t      exp_data;
  logic                      init_pend, esc_m, started, exp_vld, exp_known;
  logic                      fill_m, done_m;
  int unsigned               fill_left;
  int unsigned               chk_cnt = 0;
  int unsigned               err_cnt = 0;

  assign check_cnt_o = chk_cnt;
  assign error_cnt_o = err_cnt;

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  // Key XOR nonce XOR (address times the mix constant), kept to 32 bits
  function automatic sram_ctrl_pkg::data_t keystream(input sram_ctrl_pkg::addr_t a,
                                                     input sram_ctrl_pkg::key_t  k,
                                                     input sram_ctrl_pkg::key_t  n);
    sram_ctrl_pkg::key_t prod;
    prod = sram_ctrl_pkg::key_t'(a) * `SRAM_ADDR_MIX;
    return k ^ n ^ prod;
  endfunction

  // Galois step: shift right, fold in the mask if a one fell out
  function automatic sram_ctrl_pkg::key_t lfsr_next(input sram_ctrl_pkg::key_t s);
    sram_ctrl_pkg::key_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ `SRAM_LFSR_TAPS;
    end
    return n;
  endfunction

  // Stored scrambled word seen through the keystream of the read cycle
  function automatic sram_ctrl_pkg::data_t expect_read(input sram_ctrl_pkg::data_t stored,
                                                       input sram_ctrl_pkg::addr_t a,
                                                       input sram_ctrl_pkg::key_t  k,
                                                       input sram_ctrl_pkg::key_t  n);
    return stored ^ keystream(a, k, n);
  endfunction

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_fault(input string msg);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Whole array as the fill leaves it, seed is the nonce with bit 0 set
  task automatic fill_model();
    sram_ctrl_pkg::key_t s;
    s = nonce_m | sram_ctrl_pkg::key_t'(1);
    for (int k = 0; k < `SRAM_DEPTH; k++) begin
      scr_mem[k] = s ^ keystream(sram_ctrl_pkg::addr_t'(k), key_m, nonce_m);
      written[k] = 1'b1;
      s = lfsr_next(s);
    end
  endtask

  //////////////////////////////
  // Mid-cycle model and compare
  //////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      if (key_req_i || gnt_i || rvalid_i || init_done_i) begin
        report_fault("an output is high while reset is asserted");
      end
      for (int k = 0; k < `SRAM_DEPTH; k++) begin
        written[k] = 1'b0;
      end
      phase     = sram_ctrl_pkg::KeyIdle;
      key_m     = `SRAM_DEFAULT_KEY;
      nonce_m   = `SRAM_DEFAULT_NONCE;
      init_pend = 1'b0;
      esc_m     = 1'b0;
      exp_vld   = 1'b0;
      started   = 1'b0;
      fill_m    = 1'b0;
      done_m    = 1'b0;
      fill_left = 0;
    end else if (!started) begin
      // Grant register still settling out of reset
      started = 1'b1;
    end else begin
      // Response to the read granted one cycle earlier
      if (exp_vld && !rvalid_i) begin
        report_fault("no read response one cycle after the grant");
      end else if (!exp_vld && rvalid_i) begin
        report_fault("rvalid_o rose without a granted read");
      end else if (exp_vld && exp_known) begin
        chk_cnt++;
        if (rdata_i !== exp_data) begin
          err_cnt++;
          $display("[ERROR] %0t ns rdata_o: got 0x%08h, expected 0x%08h",
                   $time, rdata_i, exp_data);
        end
      end
      exp_vld = 1'b0;
      check_bit("gnt_o", gnt_i, phase == sram_ctrl_pkg::KeyIdle && !init_pend && !esc_m);
      check_bit("key_req_o", key_req_i, phase == sram_ctrl_pkg::KeyReq);
      check_bit("key_valid_o", key_valid_i, phase == sram_ctrl_pkg::KeyIdle && !esc_m);
      check_bit("escalated_o", escalated_i, esc_m);
      check_bit("init_done_o", init_done_i, done_m);
      // Host access uses the key of this cycle
      if (req_i && gnt_i) begin
        if (we_i) begin
          scr_mem[addr_i] = wdata_i ^ keystream(addr_i, key_m, nonce_m);
          written[addr_i] = 1'b1;
        end else begin
          exp_vld   = 1'b1;
          exp_known = written[addr_i];
          exp_data  = expect_read(scr_mem[addr_i], addr_i, key_m, nonce_m);
        end
      end
      // Fill seeded once no exchange is pending, then one word per cycle
      if (fill_m) begin
        fill_left--;
        if (fill_left == 0) begin
          // Last word written, memory now holds the LFSR sequence
          fill_model();
          fill_m    = 1'b0;
          init_pend = 1'b0;
          done_m    = 1'b1;
        end
      end else if (init_pend && phase == sram_ctrl_pkg::KeyIdle) begin
        fill_m    = 1'b1;
        fill_left = `SRAM_DEPTH;
      end
      // Four-phase exchange, key taken on the first ack
      case (phase)
        sram_ctrl_pkg::KeyIdle: begin
          if (renew_key_i && !init_pend && !esc_m) begin
            phase = sram_ctrl_pkg::KeyReq;
          end
        end
        sram_ctrl_pkg::KeyReq: begin
          if (key_ack_i) begin
            phase = sram_ctrl_pkg::KeyRelease;
            key_m   = key_i;
            nonce_m = nonce_i;
          end
        end
        default: begin
          if (!key_ack_i) begin
            phase = sram_ctrl_pkg::KeyIdle;
          end
        end
      endcase
      // New init only from idle and before escalation took hold
      if (init_i && !init_pend && !esc_m) begin
        init_pend = 1'b1;
        done_m    = 1'b0;
      end
      // Done flag follows the registered escalation state
      if (esc_m) begin
        done_m = 1'b0;
      end
      // Escalation overrides any capture in the same cycle
      if (escalate_i || esc_m) begin
        esc_m   = 1'b1;
        key_m   = `SRAM_DEFAULT_KEY;
        nonce_m = `SRAM_DEFAULT_NONCE;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_sram_ctrl.sv ====
// Testbench for the scrambled SRAM controller
// Clock, reset, key source model, host stimulus and watchdog

`timescale 1ns/1ns
`default_nettype none

`include "sram_ctrl_macros.svh"

module tb_sram_ctrl;

  localparam int unsigned num_words   = 16;
  localparam int unsigned new_words   = 8;
  localparam int unsigned hold_cycles = 20;
  // Rough cycle budget of each test, exchanges counted at their longest
  localparam int unsigned test_cycles = 3 + (2 * num_words + 4)
                                      + (2 * `SRAM_DEPTH + 8) + 24
                                      + (num_words + 2 * new_words + 4)
                                      + (24 + 2 * `SRAM_DEPTH + 8)
                                      + (hold_cycles + 8) + 10;
  localparam int unsigned watchdog_cycles = test_cycles + 2000;

  logic                 clk_i, rst_ni;
  logic                 req_i, we_i, gnt_o, rvalid_o;
  sram_ctrl_pkg::addr_t addr_i;
  sram_ctrl_pkg::data_t wdata_i, rdata_o;
  logic                 renew_key_i, init_i, escalate_i;
  logic                 key_req_o, key_ack_i;
  sram_ctrl_pkg::key_t  key_i, nonce_i;
  logic                 key_valid_o, init_done_o, escalated_o;
  int unsigned          chk_cnt, err_cnt;
  sram_ctrl_pkg::addr_t wr_addr [num_words];
  integer               seed = 32'h94513671;

  sram_ctrl dut0 (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .gnt_o, .rvalid_o, .rdata_o,
    .renew_key_i, .init_i, .escalate_i, .key_req_o, .key_ack_i, .key_i, .nonce_i,
    .key_valid_o, .init_done_o, .escalated_o
  );

  sram_ctrl_checker chk0 (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i,
    .gnt_i (gnt_o), .rvalid_i (rvalid_o), .rdata_i (rdata_o),
    .renew_key_i, .init_i, .escalate_i,
    .key_req_i (key_req_o), .key_ack_i, .key_i, .nonce_i,
    .key_valid_i (key_valid_o), .init_done_i (init_done_o), .escalated_i (escalated_o),
    .check_cnt_o (chk_cnt), .error_cnt_o (err_cnt)
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Key source
  //////////////////////////////

  initial begin : key_source
    int unsigned         delay;
    sram_ctrl_pkg::key_t new_key, new_nonce;
    key_ack_i = 1'b0;
    key_i     = '0;
    nonce_i   = '0;
    forever begin
      @(negedge clk_i);
      if (key_req_o) begin
        // Draws happen mid-cycle, apart from the stimulus draws
        delay     = ($unsigned($random(seed)) % 6) + 1;
        new_key   = $random(seed);
        new_nonce = $random(seed);
        repeat (delay) @(posedge clk_i);
        #2;
        key_ack_i = 1'b1;
        key_i     = new_key;
        nonce_i   = new_nonce;
        // Hold the ack until the request is withdrawn
        do @(negedge clk_i); while (key_req_o);
        @(posedge clk_i);
        #2;
        key_ack_i = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Host helpers
  //////////////////////////////

  // One access, request held until granted
  task automatic host_access(input logic write, input sram_ctrl_pkg::addr_t addr,
                             input sram_ctrl_pkg::data_t data);
    req_i   = 1'b1;
    we_i    = write;
    addr_i  = addr;
    wdata_i = data;
    do @(negedge clk_i); while (!gnt_o);
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  // One-cycle command pulses
  task automatic pulse_cmd(input logic do_init, input logic do_renew);
    init_i      = do_init;
    renew_key_i = do_renew;
    @(posedge clk_i);
    #2;
    init_i      = 1'b0;
    renew_key_i = 1'b0;
  endtask

  task automatic wait_init_done();
    do @(negedge clk_i); while (!init_done_o);
    @(posedge clk_i);
    #2;
  endtask

  task automatic read_all();
    for (int unsigned a = 0; a < `SRAM_DEPTH; a++) begin
      host_access(1'b0, sram_ctrl_pkg::addr_t'(a), '0);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : stimulus
    sram_ctrl_pkg::addr_t a;
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    renew_key_i = 1'b0;
    init_i      = 1'b0;
    escalate_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    // Default key, writes then back-to-back reads
    for (int unsigned i = 0; i < num_words; i++) begin
      wr_addr[i] = sram_ctrl_pkg::addr_t'($random(seed));
      host_access(1'b1, wr_addr[i], sram_ctrl_pkg::data_t'($random(seed)));
    end
    for (int unsigned i = 0; i < num_words; i++) begin
      host_access(1'b0, wr_addr[i], '0);
    end
    // Init fill from the default nonce
    pulse_cmd(1'b1, 1'b0);
    wait_init_done();
    read_all();
    // Key renewal, second pulse lands mid-exchange
    pulse_cmd(1'b0, 1'b1);
    @(posedge clk_i);
    #2;
    pulse_cmd(1'b0, 1'b1);
    do @(negedge clk_i); while (!key_valid_o);
    @(posedge clk_i);
    #2;
    // Old words under the new key, then fresh words
    for (int unsigned i = 0; i < num_words; i++) begin
      host_access(1'b0, wr_addr[i], '0);
    end
    for (int unsigned i = 0; i < new_words; i++) begin
      a = sram_ctrl_pkg::addr_t'($random(seed));
      host_access(1'b1, a, sram_ctrl_pkg::data_t'($random(seed)));
      host_access(1'b0, a, '0);
    end
    // Init together with renewal waits for the new nonce
    pulse_cmd(1'b1, 1'b1);
    wait_init_done();
    read_all();
    // Escalation with a read granted in the same cycle
    escalate_i = 1'b1;
    host_access(1'b0, wr_addr[0], '0);
    do @(negedge clk_i); while (!escalated_o);
    @(posedge clk_i);
    #2;
    req_i = 1'b1;
    repeat (hold_cycles) @(posedge clk_i);
    #2;
    req_i = 1'b0;
    repeat (4) @(posedge clk_i);
    $display("Read checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Read checks: %0d, errors: %0d", chk_cnt, err_cnt);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
sram_ctrl_pkg.sv
sram_key_req.sv
sram_init_arb.sv
sram_scr_mem.sv
sram_ctrl.sv
sram_ctrl_checker.sv
tb_sram_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the scrambled SRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_sram_ctrl \
  -f flist.f \
  --Mdir obj_dir \
  -o tb_sram_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sram_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
